// File: Makefile
# verilator build and run of the data cache testbench

sim:
	verilator --binary --timing -j 0 --top-module tb_dcache -f tb.f -o tb_dcache
	./obj_dir/tb_dcache 2>&1 | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: cache_bus_pkg.sv
// processor request and wishbone classic port types, shared by the cache and its testbench
`default_nettype none

package cache_bus_pkg;

    // one load or store from the processor, held steady until accepted
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } cpu_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // wishbone classic, single transfers only
    ////////////////////////////////////////////////////////////////////////////

    // master side, driven by the cache controller
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    // slave side, ack ends the current transfer
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

// File: cache_geom_pkg.sv
// cache organisation constants, controller states and the array write command
`default_nettype none

package cache_geom_pkg;

    // two ways, the lru keeps a single bit per set
    localparam int WAYS = 2;

    ////////////////////////////////////////////////////////////////////////////
    // controller
    ////////////////////////////////////////////////////////////////////////////

    // lookup lasts one cycle, refill and write_through wait on the bus
    typedef enum logic [1:0] {
        idle          = 2'd0,
        lookup        = 2'd1,
        refill        = 2'd2,
        write_through = 2'd3
    } ctrl_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // array write command from the controller to the tag and data arrays
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        // one enable per way
        logic [WAYS-1:0] way_we;
        // tag and valid, set with the last refill word
        logic            tag_we;
        // full word from the bus, strobes ignored
        logic            refill;
        // word number within the line, upper bits unused
        logic [7:0]      word;
        logic [31:0]     data;
        logic [3:0]      sel;
    } array_wr_t;

endpackage

`default_nettype wire

// File: dcache_ctrl.sv
// cache control FSM that runs lookup, line refill, write-through and the processor responses
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int index_width = 4,
    parameter int offset_width = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic                              req_valid,
    output logic                                   req_ready,
    output logic                                   capture,
    input  cache_bus_pkg::cpu_req_t                buf_req,
    input  wire logic [index_width-1:0]            index,
    input  wire logic [offset_width-1:0]           word,
    input  wire logic [cache_geom_pkg::WAYS-1:0]   hit,
    input  wire logic [31:0]                       rdata_way,
    input  wire logic                              victim,
    output logic                                   touch,
    output logic                                   touch_way,
    output cache_geom_pkg::array_wr_t              wr,
    output logic                                   rsp_valid,
    output logic [31:0]                            rdata,
    output cache_bus_pkg::wb_m2s_t                 wb_o,
    input  cache_bus_pkg::wb_s2m_t                 wb_i
);

    localparam int line_lsb = offset_width + 2;
    localparam int tag_lsb = index_width + offset_width + 2;
    localparam logic [offset_width-1:0] last_word = '1;

    cache_geom_pkg::ctrl_state_e state;
    cache_geom_pkg::ctrl_state_e state_nx;

    // refill word counter, counts acks
    logic [offset_width-1:0] cnt;
    // requested word, caught off the bus during refill
    logic [31:0]             fill_q;
    logic [31:0]             fill_word;
    logic [31:0]             line_adr;
    logic                    any_hit;

    assign any_hit = |hit;
    assign capture = req_valid && req_ready;

    // requested word may arrive in the very last ack
    assign fill_word = (cnt == word) ? wb_i.dat : fill_q;

    // first byte of the line, tag bits kept and offset cleared
    assign line_adr = ((buf_req.addr >> tag_lsb) << tag_lsb) | (32'(index) << line_lsb);

    ////////////////////////////////////////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx  = state;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rdata     = rdata_way;
        touch     = 1'b0;
        touch_way = hit[1];
        wr        = '0;
        wb_o      = '0;

        case (state)
            cache_geom_pkg::idle: begin
                req_ready = 1'b1;
            end

            cache_geom_pkg::lookup: begin
                if (!buf_req.we && any_hit) begin
                    // read hit, answered now
                    req_ready = 1'b1;
                    rsp_valid = 1'b1;
                    touch     = 1'b1;
                end else if (buf_req.we) begin
                    state_nx = cache_geom_pkg::write_through;
                    if (any_hit) begin
                        // store hit updates the line here, memory follows
                        touch     = 1'b1;
                        wr.way_we = hit;
                        wr.word   = 8'(word);
                        wr.data   = buf_req.wdata;
                        wr.sel    = buf_req.sel;
                    end
                end else begin
                    state_nx = cache_geom_pkg::refill;
                end
            end

            cache_geom_pkg::refill: begin
                wb_o.cyc = 1'b1;
                wb_o.stb = 1'b1;
                wb_o.adr = line_adr | (32'(cnt) << 2);
                wb_o.sel = 4'hf;
                if (wb_i.ack) begin
                    wr.way_we[victim] = 1'b1;
                    wr.refill = 1'b1;
                    wr.word   = 8'(cnt);
                    wr.data   = wb_i.dat;
                    if (cnt == last_word) begin
                        // line complete, tag goes valid with the last word
                        wr.tag_we = 1'b1;
                        touch     = 1'b1;
                        touch_way = victim;
                        rsp_valid = 1'b1;
                        rdata     = fill_word;
                        req_ready = 1'b1;
                    end
                end
            end

            cache_geom_pkg::write_through: begin
                wb_o.cyc = 1'b1;
                wb_o.stb = 1'b1;
                wb_o.we  = 1'b1;
                wb_o.adr = buf_req.addr;
                wb_o.dat = buf_req.wdata;
                wb_o.sel = buf_req.sel;
                if (wb_i.ack) begin
                    rsp_valid = 1'b1;
                    req_ready = 1'b1;
                end
            end

            default: begin
                state_nx = cache_geom_pkg::idle;
            end
        endcase

        // finished, either straight into the next lookup or back to idle
        if (req_ready) begin
            state_nx = req_valid ? cache_geom_pkg::lookup : cache_geom_pkg::idle;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= cache_geom_pkg::idle;
            cnt   <= '0;
        end else begin
            state <= state_nx;
            if (state == cache_geom_pkg::lookup) begin
                cnt <= '0;
            end else if (state == cache_geom_pkg::refill && wb_i.ack) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_geom_pkg::refill && wb_i.ack && cnt == word) begin
            fill_q <= wb_i.dat;
        end
    end

endmodule

`default_nettype wire

// File: dcache_lru.sv
// one lru bit per set, naming the way to be replaced on the next refill
`default_nettype none
`timescale 1ns/1ps

module dcache_lru #(
    parameter int index_width = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [index_width-1:0] index,
    input  wire logic                   touch,
    input  wire logic                   touch_way,
    output logic                        victim
);

    localparam int sets = 1 << index_width;

    // bit set means way 1 is the least recently used
    logic [sets-1:0] lru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (touch) begin
            // the way just used becomes the most recent
            lru_q[index] <= ~touch_way;
        end
    end

    assign victim = lru_q[index];

endmodule

`default_nettype wire

// File: dcache_req_buf.sv
// holds the accepted processor request and splits its address into tag, set index and word
`default_nettype none
`timescale 1ns/1ps

module dcache_req_buf #(
    parameter int index_width = 4,
    parameter int offset_width = 2,
    localparam int tag_width = 30 - index_width - offset_width
) (
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire logic                     capture,
    input  cache_bus_pkg::cpu_req_t       req,
    output cache_bus_pkg::cpu_req_t       buf_req,
    output logic [tag_width-1:0]          tag,
    output logic [index_width-1:0]        index,
    output logic [offset_width-1:0]       word
);

    // bit positions inside a byte address
    localparam int word_lsb = 2;
    localparam int index_lsb = word_lsb + offset_width;

    // request stays here until the controller takes the next one
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_req <= '0;
        end else if (capture) begin
            buf_req <= req;
        end
    end

    // address split, used by arrays, lru and controller alike
    assign word  = buf_req.addr[word_lsb +: offset_width];
    assign index = buf_req.addr[index_lsb +: index_width];
    assign tag   = buf_req.addr[31 -: tag_width];

endmodule

`default_nettype wire

// File: dcache_top.sv
// two-way write-through data cache between a processor port and a wishbone classic bus
`default_nettype none
`timescale 1ns/1ps

module dcache_top #(
    parameter int index_width = 4,
    parameter int offset_width = 2
) (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                req_valid,
    input  cache_bus_pkg::cpu_req_t  req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    output logic [31:0]              rdata,
    output cache_bus_pkg::wb_m2s_t   wb_o,
    input  cache_bus_pkg::wb_s2m_t   wb_i
);

    localparam int tag_width = 30 - index_width - offset_width;

    cache_bus_pkg::cpu_req_t             buf_req;
    cache_geom_pkg::array_wr_t           wr;
    logic                                capture;
    logic [tag_width-1:0]                tag;
    logic [index_width-1:0]              index;
    logic [offset_width-1:0]             word;
    logic [index_width-1:0]              rd_index;
    logic [cache_geom_pkg::WAYS-1:0]     hit;
    logic [31:0]                         way_rdata;
    logic                                victim;
    logic                                touch;
    logic                                touch_way;

    // set of the incoming request, so the arrays are read during capture
    assign rd_index = req.addr[offset_width + 2 +: index_width];

    dcache_req_buf #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_req_buf (
        .clk     (clk),
        .rstn    (rstn),
        .capture (capture),
        .req     (req),
        .buf_req (buf_req),
        .tag     (tag),
        .index   (index),
        .word    (word)
    );

    dcache_ways #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_ways (
        .clk      (clk),
        .rstn     (rstn),
        .rd_index (rd_index),
        .tag      (tag),
        .word     (word),
        .wr_index (index),
        .wr       (wr),
        .hit      (hit),
        .rdata    (way_rdata)
    );

    dcache_lru #(
        .index_width (index_width)
    ) u_lru (
        .clk       (clk),
        .rstn      (rstn),
        .index     (index),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    dcache_ctrl #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .capture   (capture),
        .buf_req   (buf_req),
        .index     (index),
        .word      (word),
        .hit       (hit),
        .rdata_way (way_rdata),
        .victim    (victim),
        .touch     (touch),
        .touch_way (touch_way),
        .wr        (wr),
        .rsp_valid (rsp_valid),
        .rdata     (rdata),
        .wb_o      (wb_o),
        .wb_i      (wb_i)
    );

endmodule

`default_nettype wire

// File: dcache_ways.sv
// tag, valid and data arrays of the two ways, with hit compare and read word select
`default_nettype none
`timescale 1ns/1ps

module dcache_ways #(
    parameter int index_width = 4,
    parameter int offset_width = 2,
    localparam int tag_width = 30 - index_width - offset_width
) (
    input  wire logic                              clk,
    input  wire logic                              rstn,
    input  wire logic [index_width-1:0]            rd_index,
    input  wire logic [tag_width-1:0]              tag,
    input  wire logic [offset_width-1:0]           word,
    input  wire logic [index_width-1:0]            wr_index,
    input  cache_geom_pkg::array_wr_t              wr,
    output logic [cache_geom_pkg::WAYS-1:0]        hit,
    output logic [31:0]                            rdata
);

    localparam int sets = 1 << index_width;
    localparam int words = 1 << offset_width;

    logic [tag_width-1:0]   tag_q   [cache_geom_pkg::WAYS][sets];
    logic [sets-1:0]        valid_q [cache_geom_pkg::WAYS];
    logic [31:0]            data_q  [cache_geom_pkg::WAYS][sets][words];

    // set address of the lookup, taken at the capture edge
    logic [index_width-1:0] rd_q;
    logic [offset_width-1:0] wr_word;
    logic [31:0]            way_word [cache_geom_pkg::WAYS];

    assign wr_word = wr.word[offset_width-1:0];

    // registered read address, so writes on the capture edge are seen in lookup
    always_ff @(posedge clk) begin
        rd_q <= rd_index;
    end

    ////////////////////////////////////////////////////////////////////////////
    // array updates
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
                if (wr.way_we[w] && wr.tag_we) begin
                    valid_q[w][wr_index] <= 1'b1;
                end
            end
        end
    end

    // refill writes every byte, a store hit only the strobed ones
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (wr.way_we[w]) begin
                if (wr.tag_we) begin
                    tag_q[w][wr_index] <= tag;
                end
                for (int b = 0; b < 4; b++) begin
                    if (wr.refill || wr.sel[b]) begin
                        data_q[w][wr_index][wr_word][8*b +: 8] <= wr.data[8*b +: 8];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            hit[w]      = valid_q[w][rd_q] && (tag_q[w][rd_q] == tag);
            way_word[w] = data_q[w][rd_q][word];
        end
    end

    // at most one way can match, so way 1 decides the select
    assign rdata = way_word[hit[1]];

endmodule

`default_nettype wire

// File: tb.f
cache_bus_pkg.sv
cache_geom_pkg.sv
dcache_req_buf.sv
dcache_ways.sv
dcache_lru.sv
dcache_ctrl.sv
dcache_top.sv
tb_wb_mem.sv
tb_dcache.sv

// File: tb_dcache.sv
// testbench for the data cache, random loads and stores checked against a cache and memory model
`default_nettype none
`timescale 1ns/1ps

module tb_dcache;

    localparam int index_width = 4;
    localparam int offset_width = 2;
    localparam int words = 1 << offset_width;
    localparam int sets = 1 << index_width;
    localparam int num_random = 2000;
    localparam int total_requests = 6 + num_random;
    localparam int timeout_cycles = num_random * 40;
    // set 5 with tags 0, 1 and 2
    localparam logic [31:0] lru_seq [6] = '{32'h050, 32'h150, 32'h050, 32'h250, 32'h050, 32'h150};

    logic                    clk = 1'b0;
    logic                    rstn;
    logic                    req_valid;
    cache_bus_pkg::cpu_req_t req;
    logic                    req_ready;
    logic                    rsp_valid;
    logic [31:0]             rdata;
    cache_bus_pkg::wb_m2s_t  wb_o;
    cache_bus_pkg::wb_s2m_t  wb_i;
    logic [1:0]              wait_cycles = 2'd0;

    logic [31:0] req_seed = 32'h889;
    logic [31:0] ack_seed = 32'h889;
    int          cycles = 0;
    int          responses = 0;

    // model state, owned by the monitor
    logic [31:0] model_mem [256];
    int          model_tag [2][sets];
    logic        model_valid [2][sets];
    int          model_lru [sets];
    cache_bus_pkg::cpu_req_t pend_req;
    cache_bus_pkg::wb_m2s_t  last_bus;
    logic        pend;
    logic        held;
    logic [31:0] exp_rdata;
    logic [31:0] line_base;
    int          exp_reads;
    int          exp_writes;
    int          reads_seen;
    int          writes_seen;
    int          accept_cycle;

    dcache_top #(
        .index_width  (index_width),
        .offset_width (offset_width)
    ) u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rdata     (rdata),
        .wb_o      (wb_o),
        .wb_i      (wb_i)
    );

    tb_wb_mem u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .wait_cycles (wait_cycles),
        .m2s         (wb_o),
        .s2m         (wb_i)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(inout logic [31:0] seed, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], seed[0]};
            seed = lfsr_step(seed);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "run stopped at the first mismatch");
        end
    endtask

    task automatic random_request(output cache_bus_pkg::cpu_req_t r);
        logic [31:0] v;
        r = '0;
        draw_bits(req_seed, 8, v);
        r.addr = {22'd0, v[7:0], 2'b00};
        draw_bits(req_seed, 2, v);
        r.we = (v[1:0] == 2'd0);
        draw_bits(req_seed, 32, v);
        r.wdata = v;
        draw_bits(req_seed, 4, v);
        r.sel = (v[3:0] == 4'd0) ? 4'hf : v[3:0];
    endtask

    // called at a rising edge, returns at the edge that accepts the request
    task automatic send_request(input cache_bus_pkg::cpu_req_t r);
        req       <= r;
        req_valid <= 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // predicts bus traffic and read data, then applies the request to the model
    task automatic model_accept(input cache_bus_pkg::cpu_req_t r);
        int idx;
        int tg;
        int way;
        int w;
        w   = int'(r.addr[9:2]);
        idx = int'((r.addr >> (offset_width + 2)) & 32'(sets - 1));
        tg  = int'(r.addr >> (index_width + offset_width + 2));
        way = -1;
        for (int i = 0; i < 2; i++) begin
            if (model_valid[i][idx] && model_tag[i][idx] == tg) begin
                way = i;
            end
        end
        exp_reads  = 0;
        exp_writes = 0;
        exp_rdata  = model_mem[w];
        line_base  = r.addr & ~32'(words * 4 - 1);
        if (r.we) begin
            // write-through, no allocate on a miss
            exp_writes = 1;
            for (int b = 0; b < 4; b++) begin
                if (r.sel[b]) begin
                    model_mem[w][8*b +: 8] = r.wdata[8*b +: 8];
                end
            end
            if (way >= 0) begin
                model_lru[idx] = 1 - way;
            end
        end else if (way >= 0) begin
            model_lru[idx] = 1 - way;
        end else begin
            exp_reads = words;
            way = model_lru[idx];
            model_tag[way][idx] = tg;
            model_valid[way][idx] = 1'b1;
            model_lru[idx] = 1 - way;
        end
        pend_req     = r;
        pend         = 1'b1;
        reads_seen   = 0;
        writes_seen  = 0;
        accept_cycle = cycles;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitor, sampled on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 256; i++) begin
                model_mem[i] = u_mem.mem[i];
            end
            for (int s = 0; s < sets; s++) begin
                model_valid[0][s] = 1'b0;
                model_valid[1][s] = 1'b0;
                model_lru[s] = 0;
            end
            pend = 1'b0;
            held = 1'b0;
        end else begin
            // classic single transfers, cyc and stb move together
            check_value("wb_o.cyc", 32'(wb_o.cyc), 32'(wb_o.stb));
            // bus quiet while no request is outstanding
            if (!pend) begin
                check_value("wb_o.stb with no request pending", 32'(wb_o.stb), 32'd0);
            end
            // a stalled transfer keeps its address, data and strobes
            if (held) begin
                check_value("wb_o.stb held", 32'(wb_o.stb), 32'd1);
                check_value("wb_o.adr held", wb_o.adr, last_bus.adr);
                check_value("wb_o.dat held", wb_o.dat, last_bus.dat);
                check_value("wb_o.we held", 32'(wb_o.we), 32'(last_bus.we));
                check_value("wb_o.sel held", 32'(wb_o.sel), 32'(last_bus.sel));
            end
            // bus first, the last ack and its response share a cycle
            if (wb_o.cyc && wb_o.stb && wb_i.ack) begin
                check_value("request pending at wb ack", 32'(pend), 32'd1);
                if (wb_o.we) begin
                    check_value("wb_o.adr", wb_o.adr, pend_req.addr);
                    check_value("wb_o.dat", wb_o.dat, pend_req.wdata);
                    check_value("wb_o.sel", 32'(wb_o.sel), 32'(pend_req.sel));
                    writes_seen++;
                end else begin
                    check_value("wb_o.adr", wb_o.adr, line_base + 32'(reads_seen * 4));
                    reads_seen++;
                end
            end
            held     = wb_o.stb && !wb_i.ack;
            last_bus = wb_o;
            if (rsp_valid) begin
                check_value("request pending at rsp_valid", 32'(pend), 32'd1);
                check_value("wishbone reads", reads_seen, exp_reads);
                check_value("wishbone writes", writes_seen, exp_writes);
                if (!pend_req.we) begin
                    check_value("rdata", rdata, exp_rdata);
                end
                if (!pend_req.we && exp_reads == 0) begin
                    check_value("read hit latency", cycles - accept_cycle, 1);
                end
                pend = 1'b0;
                responses++;
            end
            if (req_valid && req_ready) begin
                model_accept(req);
            end
        end
    end

    always @(posedge clk) begin
        logic [31:0] v;
        draw_bits(ack_seed, 2, v);
        wait_cycles <= v[1:0];
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        cache_bus_pkg::cpu_req_t r;
        logic [31:0] v;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("req_ready after reset", 32'(req_ready), 32'd1);
        check_value("wb_o.cyc after reset", 32'(wb_o.cyc), 32'd0);
        check_value("wb_o.stb after reset", 32'(wb_o.stb), 32'd0);
        check_value("rsp_valid after reset", 32'(rsp_valid), 32'd0);
        @(posedge clk);

        // tag 2 evicts tag 1, so tag 0 hits and tag 1 misses again
        for (int i = 0; i < 6; i++) begin
            r = '0;
            r.addr = lru_seq[i];
            r.sel = 4'hf;
            send_request(r);
        end

        for (int n = 0; n < num_random; n++) begin
            random_request(r);
            send_request(r);
            draw_bits(req_seed, 2, v);
            if (v[1:0] == 2'd0) begin
                req_valid <= 1'b0;
                @(posedge clk);
            end
        end
        req_valid <= 1'b0;

        while (responses != total_requests) begin
            @(posedge clk);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_wb_mem.sv
// wishbone classic memory slave for the cache testbench, 256 words with a per-transfer ack delay
`default_nettype none
`timescale 1ns/1ps

module tb_wb_mem (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic [1:0]        wait_cycles,
    input  cache_bus_pkg::wb_m2s_t m2s,
    output cache_bus_pkg::wb_s2m_t s2m
);

    logic [31:0] mem [256];
    // wait cycles spent on the current transfer
    logic [1:0]  waited;
    logic [7:0]  widx;

    // 1 KiB window, upper address bits ignored
    assign widx = m2s.adr[9:2];

    // each byte lane carries its own function of the word address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'hc3, ~8'(i), 8'(i) + 8'h11, 8'(i)};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered ack, dropped for one cycle after every transfer
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s2m    <= '0;
            waited <= '0;
        end else begin
            s2m.ack <= 1'b0;
            if (m2s.cyc && m2s.stb && !s2m.ack) begin
                if (waited >= wait_cycles) begin
                    s2m.ack <= 1'b1;
                    waited  <= '0;
                    if (m2s.we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (m2s.sel[b]) begin
                                mem[widx][8*b +: 8] <= m2s.dat[8*b +: 8];
                            end
                        end
                    end else begin
                        s2m.dat <= mem[widx];
                    end
                end else begin
                    waited <= waited + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
